// ==== all.f ====
+incdir+verilog
verilog/uart_pkg.sv
verilog/rx_fifo_if.sv
verilog/baudgen.sv
verilog/uart_rx.sv
verilog/rx_fifo.sv
verilog/uart_axil_regs.sv
verilog/uart_rx_top.sv
verif/uart_rx_assertions.sv
verif/uart_rx_tb.sv

// ==== verif/uart_rx_tb.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_tb;
	import uart_pkg::*;

	localparam int CLK_NS = 10;
	localparam int BIT_CLKS = `UART_CLKFREQ / `UART_BAUD; // 64 clocks per bit
	localparam int BIT_NS = BIT_CLKS * CLK_NS;
	localparam int NUM_FRAMES = 13;
	// 10 bits per frame, up to 2 bits of gap, extra rows for reset and glitch
	localparam int WATCHDOG_NS = (NUM_FRAMES + 4) * 12 * BIT_NS + 20000;

	typedef struct packed
	{
		uart_byte_t data;
		logic stop;       // Stop bit level
		logic read_back;
	} frame_entry_t;

	// Three good bytes, a bad stop bit, then nine bytes into the 8 deep FIFO
	frame_entry_t frames [NUM_FRAMES] = '{
		'{8'h55, 1'b1, 1'b1},
		'{8'hA3, 1'b1, 1'b0},
		'{8'h0F, 1'b1, 1'b1},
		'{8'h3C, 1'b0, 1'b1},
		'{8'h01, 1'b1, 1'b0},
		'{8'h80, 1'b1, 1'b0},
		'{8'hFF, 1'b1, 1'b0},
		'{8'h00, 1'b1, 1'b0},
		'{8'h7E, 1'b1, 1'b0},
		'{8'h92, 1'b1, 1'b0},
		'{8'h24, 1'b1, 1'b0},
		'{8'hDB, 1'b1, 1'b0},
		'{8'h6D, 1'b1, 1'b1}
	};

	logic clk_i;
	logic rst_i;
	logic serial_in;
	axil_addr_t awaddr;
	axil_addr_t araddr;
	axil_data_t wdata;
	axil_data_t rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;

	uart_byte_t model_q [$]; // Bytes expected in the FIFO
	logic overrun_exp = 1'b0;
	logic frame_err_exp = 1'b0;
	int checks = 0;
	int errors = 0;

	uart_rx_top i_dut (.*);

	initial
	begin
		clk_i = 1'b0;
		forever #(CLK_NS / 2) clk_i = ~clk_i;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	function automatic axil_data_t exp_status();
		axil_data_t s;
		s = '0;
		s[0] = (model_q.size() != 0);
		s[1] = overrun_exp;
		s[2] = frame_err_exp;
		s[11:8] = 4'(model_q.size());
		return s;
	endfunction

	// Start bit, LSB first data, chosen stop level, back to idle
	task automatic send_frame(input uart_byte_t b, input logic stop);
		serial_in = 1'b0;
		#(BIT_NS);
		for (int i = 0; i < 8; i++)
		begin
			serial_in = b[i];
			#(BIT_NS);
		end
		serial_in = stop;
		#(BIT_NS);
		serial_in = 1'b1;
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b0;
		do @(negedge clk_i); while (!arready);
		@(posedge clk_i);
		#1;
		arvalid = 1'b0;
		do @(negedge clk_i); while (!rvalid);
		// Response held back two cycles
		repeat (2) @(posedge clk_i);
		#1;
		compare("arready", arready, 32'h0);
		rready = 1'b1;
		@(negedge clk_i);
		data = rdata;
		compare("rresp", rresp, 32'h0);
		@(posedge clk_i);
		#1;
		rready = 1'b0;
	endtask

	task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
		output logic [1:0] resp);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b0;
		do @(negedge clk_i); while (!(awready && wready));
		@(posedge clk_i);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		do @(negedge clk_i); while (!bvalid);
		repeat (2) @(posedge clk_i); // B channel stalled
		#1;
		bready = 1'b1;
		@(negedge clk_i);
		resp = bresp;
		@(posedge clk_i);
		#1;
		bready = 1'b0;
	endtask

	initial
	begin
		axil_data_t rd;
		axil_data_t clr;
		logic [1:0] resp;
		void'($urandom(6));
		rst_i = 1'b1;
		serial_in = 1'b1;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (10) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		axi_read(REG_STATUS, rd);
		compare("status after reset", rd, 32'h0);

		foreach (frames[i])
		begin
			send_frame(frames[i].data, frames[i].stop);
			repeat (BIT_CLKS + $urandom % BIT_CLKS) @(posedge clk_i); // Idle gap
			#1;
			if (!frames[i].stop)
				frame_err_exp = 1'b1;
			else if (model_q.size() < `UART_FIFO_DEPTH)
				model_q.push_back(frames[i].data);
			else
				overrun_exp = 1'b1;  // Dropped on a full FIFO
			axi_read(REG_STATUS, rd);
			compare("status", rd, exp_status());
			if (frames[i].read_back)
			begin
				while (model_q.size() > 0)
				begin
					axi_read(REG_RXDATA, rd);
					compare("rxdata", rd, {23'd0, 1'b1, model_q.pop_front()});
				end
				axi_read(REG_RXDATA, rd);
				compare("rxdata empty", {rd[31:8], 8'h00}, 32'h0); // Byte field undefined
				axi_read(REG_STATUS, rd);
				compare("status after empty read", rd, exp_status());
				clr = {29'd0, frame_err_exp, overrun_exp, 1'b0};
				if (clr != 0)
				begin
					axi_write(REG_CLEAR, clr, resp);
					compare("bresp", resp, 32'h0);
					overrun_exp = 1'b0;
					frame_err_exp = 1'b0;
					axi_read(REG_STATUS, rd);
					compare("status after clear", rd, exp_status());
				end
			end
		end

		// Low pulse one tick long, filtered out
		serial_in = 1'b0;
		repeat (BIT_CLKS / `UART_OVERSAMPLE) @(posedge clk_i);
		#1;
		serial_in = 1'b1;
		repeat (2 * BIT_CLKS) @(posedge clk_i);
		#1;
		axi_read(REG_STATUS, rd);
		compare("status after glitch", rd, exp_status());

		errors += i_dut.i_regs.i_assertions.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verif/uart_rx_assertions.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_assertions
(
	input logic clk_i,
	input logic rst_i,
	input logic rvalid,
	input logic rready,
	input uart_pkg::axil_data_t rdata,
	input logic bvalid,
	input logic bready,
	input uart_pkg::fifo_level_t level,
	input logic overflow
);
	import uart_pkg::*;

	int fail_count = 0; // Failed assertions so far

	rvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		rvalid && !rready |=> rvalid)
		else
		begin
			fail_count++;
			$error("rvalid dropped before rready");
		end

	bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		bvalid && !bready |=> bvalid)
		else
		begin
			fail_count++;
			$error("bvalid dropped before bready");
		end

	// Stalled read keeps its data
	rdata_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		rvalid && !rready |=> $stable(rdata))
		else
		begin
			fail_count++;
			$error("rdata changed while the read response was stalled");
		end

	level_max: assert property (@(posedge clk_i) disable iff (rst_i)
		level <= fifo_level_t'(`UART_FIFO_DEPTH))
		else
		begin
			fail_count++;
			$error("FIFO level above depth");
		end

	overflow_full: assert property (@(posedge clk_i) disable iff (rst_i)
		overflow |-> level == fifo_level_t'(`UART_FIFO_DEPTH))
		else
		begin
			fail_count++;
			$error("FIFO overflow while not full");
		end

endmodule

// FIFO side observed through the register block's interface port
bind uart_axil_regs uart_rx_assertions i_assertions
(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.bvalid(bvalid),
	.bready(bready),
	.level(fifo.level),
	.overflow(fifo.overflow)
);

// ==== verilog/uart_rx_top.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_top
(
	input logic clk_i,
	input logic rst_i,
	input logic serial_in,
	input uart_pkg::axil_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input uart_pkg::axil_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input uart_pkg::axil_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output uart_pkg::axil_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	import uart_pkg::*;

	logic tick;
	uart_byte_t rx_data;
	logic rx_valid;
	logic rx_frame_err;

	rx_fifo_if i_fifo_if ();

	baudgen
	#(
		.CLKFREQ(`UART_CLKFREQ),
		.RATE(`UART_BAUD * `UART_OVERSAMPLE)
	) i_baudgen
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.enable(1'b1),
		.tick(tick)
	);

	uart_rx i_uart_rx
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.tick(tick),
		.serial_in(serial_in),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_frame_err(rx_frame_err)
	);

	// Bad frames never reach the FIFO
	rx_fifo #(.DEPTH(`UART_FIFO_DEPTH)) i_rx_fifo
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wr_data(rx_data),
		.wr_en(rx_valid && !rx_frame_err),
		.rd(i_fifo_if.fifo)
	);

	uart_axil_regs i_regs
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.fifo(i_fifo_if.regs),
		.frame_err_evt(rx_valid && rx_frame_err),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

endmodule

// ==== verilog/uart_axil_regs.sv ====
`timescale 1ns/1ps

module uart_axil_regs
(
	input logic clk_i,
	input logic rst_i,
	rx_fifo_if.regs fifo,
	input logic frame_err_evt,
	input uart_pkg::axil_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input uart_pkg::axil_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input uart_pkg::axil_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output uart_pkg::axil_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	import uart_pkg::*;

	logic ar_hs;
	logic wr_hs;
	logic overrun;
	logic frame_err;
	logic clr_overrun;
	logic clr_frame_err;
	axil_data_t rd_mux;

	assign rresp = 2'b00;
	assign bresp = 2'b00; // Always OKAY

	// One read in flight
	assign arready = !rvalid;
	assign ar_hs = arvalid && arready;
	assign fifo.pop = ar_hs && (araddr == REG_RXDATA);

	// Address and data accepted together
	assign wr_hs = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready = wr_hs;

	assign clr_overrun = wr_hs && (awaddr == REG_CLEAR) && wstrb[0] && wdata[STAT_OVERRUN];
	assign clr_frame_err = wr_hs && (awaddr == REG_CLEAR) && wstrb[0]
		&& wdata[STAT_FRAME_ERR];

	always_comb
	begin
		rd_mux = '0;
		case (araddr)
		REG_RXDATA: rd_mux = {23'd0, fifo.valid, fifo.data};
		REG_STATUS:
		begin
			rd_mux[STAT_NOT_EMPTY] = fifo.valid;
			rd_mux[STAT_OVERRUN] = overrun;
			rd_mux[STAT_FRAME_ERR] = frame_err;
			rd_mux[STAT_LEVEL_LSB +: 4] = fifo.level;
		end
		default: rd_mux = '0; // Unmapped
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			if (ar_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Set wins over a clear in the same cycle
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			overrun <= 1'b0;
			frame_err <= 1'b0;
		end
		else
		begin
			if (fifo.overflow)
				overrun <= 1'b1;
			else if (clr_overrun)
				overrun <= 1'b0;
			if (frame_err_evt)
				frame_err <= 1'b1;
			else if (clr_frame_err)
				frame_err <= 1'b0;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (ar_hs)
			rdata <= rd_mux;
	end

endmodule

// ==== verilog/rx_fifo.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module rx_fifo
#(
	parameter int DEPTH = `UART_FIFO_DEPTH
)
(
	input logic clk_i,
	input logic rst_i,
	input uart_pkg::uart_byte_t wr_data,
	input logic wr_en,
	rx_fifo_if.fifo rd
);
	import uart_pkg::*;

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	uart_byte_t mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	fifo_level_t count;
	logic full;
	logic push;
	logic pull;

	assign full = (count == fifo_level_t'(DEPTH));
	assign push = wr_en && !full;
	assign pull = rd.pop && rd.valid; // Pop on empty ignored

	assign rd.data = mem[rd_ptr];
	assign rd.valid = (count != '0);
	assign rd.level = count;
	assign rd.overflow = wr_en && full;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pull)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Push and pop together keep the level
			if (push && !pull)
				count <= count + 1'b1;
			else if (pull && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
(
	input logic clk_i,
	input logic rst_i,
	input logic tick,
	input logic serial_in,
	output uart_pkg::uart_byte_t rx_data,
	output logic rx_valid,
	output logic rx_frame_err
);
	import uart_pkg::*;

	rx_state_t state;
	logic [1:0] sync;
	logic [1:0] maj_cnt;
	logic filt;
	logic [2:0] tick_cnt;
	logic [2:0] bit_idx;
	logic bit_end;

	// Last tick of a bit period
	assign bit_end = tick && (tick_cnt == 3'd7);

	// Line sampled only on ticks
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			sync <= 2'b11;
			maj_cnt <= 2'b11;
			filt <= 1'b1;
		end
		else if (tick)
		begin
			sync <= {sync[0], serial_in};
			if (sync[1] && maj_cnt != 2'b11)
				maj_cnt <= maj_cnt + 2'd1;
			else if (!sync[1] && maj_cnt != 2'b00)
				maj_cnt <= maj_cnt - 2'd1;
			// Saturated counter decides the level
			if (maj_cnt == 2'b00)
				filt <= 1'b0;
			else if (maj_cnt == 2'b11)
				filt <= 1'b1;
		end
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			state <= RX_IDLE;
			tick_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
			rx_frame_err <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (tick)
			begin
				tick_cnt <= tick_cnt + 3'd1;
				case (state)
				RX_IDLE:
				begin
					tick_cnt <= '0;
					if (!filt)
						state <= RX_START;
				end
				RX_START:
				begin
					// Half a bit in, start bit must still be low
					if (tick_cnt == 3'd3)
					begin
						tick_cnt <= '0;
						bit_idx <= '0;
						state <= filt ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					if (bit_end)
					begin
						rx_valid <= 1'b1;
						rx_frame_err <= !filt; // Stop bit low
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge clk_i)
	begin
		if (bit_end && state == RX_DATA)
			rx_data <= {filt, rx_data[7:1]};
	end

endmodule

// ==== verilog/baudgen.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module baudgen
#(
	parameter int CLKFREQ = `UART_CLKFREQ,
	parameter int RATE = `UART_BAUD * `UART_OVERSAMPLE
)
(
	input logic clk_i,
	input logic rst_i,
	input logic enable,
	output logic tick
);
	localparam int AW = $clog2(CLKFREQ + RATE) + 1;

	logic [AW-1:0] acc;
	logic [AW-1:0] acc_sum;

	assign acc_sum = acc + AW'(RATE);

	// Wraps by CLKFREQ so fractional ratios average out
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			acc <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= 1'b0;
			if (enable)
			begin
				if (acc_sum >= AW'(CLKFREQ))
				begin
					acc <= acc_sum - AW'(CLKFREQ);
					tick <= 1'b1;
				end
				else
					acc <= acc_sum;
			end
		end
	end

endmodule

// ==== verilog/rx_fifo_if.sv ====
`timescale 1ns/1ps

interface rx_fifo_if;
	import uart_pkg::*;

	uart_byte_t data;      // Head entry
	logic valid;           // Not empty
	logic pop;
	fifo_level_t level;
	logic overflow;        // Dropped write

	modport fifo
	(
		output data,
		output valid,
		output level,
		output overflow,
		input pop
	);

	modport regs
	(
		input data,
		input valid,
		input level,
		input overflow,
		output pop
	);

endinterface

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

	// Received data word
	typedef logic [7:0] uart_byte_t;

	// FIFO occupancy, 0 up to the full depth
	typedef logic [3:0] fifo_level_t;

	// Register space byte address
	typedef logic [3:0] axil_addr_t;

	typedef logic [31:0] axil_data_t;

	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	localparam axil_addr_t REG_RXDATA = 4'h0; // Read pops
	localparam axil_addr_t REG_STATUS = 4'h4;
	localparam axil_addr_t REG_CLEAR = 4'h8;  // Write 1 to clear

	// Status bit positions
	localparam int STAT_NOT_EMPTY = 0;
	localparam int STAT_OVERRUN = 1;
	localparam int STAT_FRAME_ERR = 2;
	localparam int STAT_LEVEL_LSB = 8;

endpackage

// ==== verilog/uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// System clock in Hz
`define UART_CLKFREQ 8000000

// Line rate, fixed at build time
`define UART_BAUD 125000

// Ticks per bit
`define UART_OVERSAMPLE 8

// Receive FIFO entries
`define UART_FIFO_DEPTH 8

`endif
